// File: hw/attn_pkg.sv
// Attention PE package with vector sizes, element types and FSM state encodings
package attn_pkg;

    // Vector geometry
    localparam int embed_dim  = 4;
    localparam int elem_idx_w = $clog2(embed_dim);

    // Power-of-two softmax, weight is 256 >> (max - score)
    localparam int weight_frac = 8;

    // Score buffer geometry
    localparam int fifo_depth = 4;
    localparam int fifo_aw    = $clog2(fifo_depth);

    // Output saturation limits
    localparam int elem_max = 127;
    localparam int elem_min = -128;

    typedef logic signed [7:0]  elem_t;   // Vector element
    typedef logic signed [17:0] score_t;  // Dot product of two vectors
    typedef logic signed [31:0] acc_t;    // Weighted totals and weight sum

    // Consumer FSM
    typedef enum logic [0:0] {
        RUNNING,
        FLUSH
    } acc_state_t;

    // Divider FSM
    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        HOLD
    } div_state_t;

endpackage

// File: hw/score_unit.sv
// Score producer, registers the query-key dot product with the value vector and last flag
`timescale 1ns/1ns

module score_unit (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            in_valid,
    output logic                                            in_ready,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       q_vec,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       k_vec,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       v_vec,
    input  logic                                            in_last,
    output logic                                            sc_valid,
    input  logic                                            sc_ready,
    output attn_pkg::score_t                                score,
    output attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       sc_v_vec,
    output logic                                            sc_last
);
    import attn_pkg::*;

    score_t dot;

    // Register free or draining this cycle
    assign in_ready = !sc_valid || sc_ready;

    // Four signed products summed at full width
    always_comb begin
        dot = '0;
        for (int i = 0; i < embed_dim; i++) begin
            dot = dot + elem_t'(q_vec[i]) * elem_t'(k_vec[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sc_valid <= 1'b0;
        end else if (in_ready) begin
            sc_valid <= in_valid;
        end
    end

    // Payload moves only on an input transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            score    <= dot;
            sc_v_vec <= v_vec;
            sc_last  <= in_last;
        end
    end

endmodule

// File: hw/score_fifo.sv
// Score buffer, four-entry fall-through FIFO for score, value vector and last flag
`timescale 1ns/1ns

module score_fifo (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            wr_valid,
    output logic                                            wr_ready,
    input  attn_pkg::score_t                                wr_score,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       wr_v_vec,
    input  logic                                            wr_last,
    output logic                                            rd_valid,
    input  logic                                            rd_ready,
    output attn_pkg::score_t                                rd_score,
    output attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       rd_v_vec,
    output logic                                            rd_last
);
    import attn_pkg::*;

    score_t                   mem_score [fifo_depth];
    elem_t [embed_dim-1:0]    mem_v     [fifo_depth];
    logic                     mem_last  [fifo_depth];

    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;   // Occupancy, 0 to fifo_depth
    logic               wr_en;
    logic               rd_en;

    assign wr_ready = (count != (fifo_aw + 1)'(fifo_depth));
    assign rd_valid = (count != '0);
    assign wr_en    = wr_valid && wr_ready;
    assign rd_en    = rd_valid && rd_ready;

    // Head entry shows without a read request
    assign rd_score = mem_score[rd_ptr];
    assign rd_v_vec = mem_v[rd_ptr];
    assign rd_last  = mem_last[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_score[wr_ptr] <= wr_score;
            mem_v[wr_ptr]     <= wr_v_vec;
            mem_last[wr_ptr]  <= wr_last;
        end
    end

endmodule

// File: hw/softmax_accum.sv
// Running softmax consumer, tracks the max score, weight sum and weighted value totals
`timescale 1ns/1ns

module softmax_accum (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            fb_valid,
    output logic                                            fb_ready,
    input  attn_pkg::score_t                                fb_score,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       fb_v_vec,
    input  logic                                            fb_last,
    output logic                                            sum_valid,
    input  logic                                            sum_ready,
    output attn_pkg::acc_t [attn_pkg::embed_dim-1:0]        acc_vec,
    output attn_pkg::acc_t                                  weight_sum
);
    import attn_pkg::*;

    acc_state_t state;
    logic       first_q;                 // No beat taken yet in this sequence
    score_t     max_q;
    acc_t       acc_q    [embed_dim];
    acc_t       wsum_q;

    logic signed [$bits(score_t):0] delta;  // Score minus max
    logic signed [$bits(score_t):0] drop;   // Max minus score
    logic       rise;
    logic       beat;
    acc_t       weight;
    acc_t       wsum_next;
    acc_t       acc_next [embed_dim];
    score_t     max_next;

    assign fb_ready   = (state == RUNNING);
    assign sum_valid  = (state == FLUSH);
    assign beat       = fb_valid && fb_ready;
    assign weight_sum = wsum_q;

    always_comb begin
        for (int i = 0; i < embed_dim; i++) begin
            acc_vec[i] = acc_q[i];
        end
    end

    always_comb begin
        delta = fb_score - max_q;
        drop  = max_q - fb_score;
        rise  = !first_q && (delta > 0);
        // New max takes full weight, older beats fade by powers of two
        if (first_q || rise) weight = acc_t'(1 << weight_frac);
        else if (drop > weight_frac) weight = '0;
        else weight = acc_t'(1 << weight_frac) >>> drop;

        if (first_q) wsum_next = '0;
        else if (rise) wsum_next = wsum_q >>> delta;  // Rescale old sum
        else wsum_next = wsum_q;
        wsum_next = wsum_next + weight;

        for (int i = 0; i < embed_dim; i++) begin
            if (first_q) acc_next[i] = '0;
            else if (rise) acc_next[i] = acc_q[i] >>> delta;
            else acc_next[i] = acc_q[i];
            acc_next[i] = acc_next[i] + weight * elem_t'(fb_v_vec[i]);
        end
        max_next = (first_q || rise) ? fb_score : max_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= RUNNING;
            first_q <= 1'b1;
        end else if (state == RUNNING) begin
            if (beat) begin
                first_q <= 1'b0;
                if (fb_last) state <= FLUSH;
            end
        end else if (sum_ready) begin
            state   <= RUNNING;  // Totals handed off, start a fresh sequence
            first_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            max_q  <= max_next;
            wsum_q <= wsum_next;
            for (int i = 0; i < embed_dim; i++) begin
                acc_q[i] <= acc_next[i];
            end
        end
    end

endmodule

// File: hw/norm_divider.sv
// Output normalizer, divides each weighted total by the weight sum one element per cycle
`timescale 1ns/1ns

module norm_divider (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            sum_valid,
    output logic                                            sum_ready,
    input  attn_pkg::acc_t [attn_pkg::embed_dim-1:0]        acc_vec,
    input  attn_pkg::acc_t                                  weight_sum,
    output logic                                            out_valid,
    input  logic                                            out_ready,
    output attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       out_vec
);
    import attn_pkg::*;

    div_state_t            state;
    logic [elem_idx_w-1:0] idx;             // Element under division
    acc_t                  num_q [embed_dim];
    acc_t                  den_q;
    acc_t                  quot;
    elem_t                 quot_sat;
    elem_t [embed_dim-1:0] out_q;

    assign sum_ready = (state == IDLE);
    assign out_valid = (state == HOLD);
    assign out_vec   = out_q;

    // Signed divide truncates toward zero, then clamp to element range
    always_comb begin
        quot = num_q[idx] / den_q;
        if (quot > elem_max) quot_sat = elem_t'(elem_max);
        else if (quot < elem_min) quot_sat = elem_t'(elem_min);
        else quot_sat = elem_t'(quot);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sum_valid) begin
                        state <= DIVIDE;
                        idx   <= '0;
                    end
                end
                DIVIDE: begin
                    idx <= idx + 1'b1;
                    if (idx == elem_idx_w'(embed_dim - 1)) state <= HOLD;
                end
                HOLD: if (out_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid && sum_ready) begin
            den_q <= weight_sum;
            for (int i = 0; i < embed_dim; i++) begin
                num_q[i] <= acc_vec[i];
            end
        end
        if (state == DIVIDE) out_q[idx] <= quot_sat;
    end

endmodule

// File: hw/attn_pe.sv
// Attention processing element, streams key/value beats through score, buffer, softmax and divide
`timescale 1ns/1ns

module attn_pe (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            in_valid,
    output logic                                            in_ready,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       q_vec,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       k_vec,
    input  attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       v_vec,
    input  logic                                            in_last,
    output logic                                            out_valid,
    input  logic                                            out_ready,
    output attn_pkg::elem_t [attn_pkg::embed_dim-1:0]       out_vec
);
    import attn_pkg::*;

    // Producer to buffer
    logic                  sc_valid, sc_ready, sc_last;
    score_t                score;
    elem_t [embed_dim-1:0] sc_v_vec;

    // Buffer to consumer
    logic                  fb_valid, fb_ready, fb_last;
    score_t                fb_score;
    elem_t [embed_dim-1:0] fb_v_vec;

    // Consumer to divider
    logic                  sum_valid, sum_ready;
    acc_t [embed_dim-1:0]  acc_vec;
    acc_t                  weight_sum;

    score_unit u_score (
        .clk(clk), .arst_n(arst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .q_vec(q_vec), .k_vec(k_vec), .v_vec(v_vec), .in_last(in_last),
        .sc_valid(sc_valid), .sc_ready(sc_ready),
        .score(score), .sc_v_vec(sc_v_vec), .sc_last(sc_last)
    );

    score_fifo u_fifo (
        .clk(clk), .arst_n(arst_n),
        .wr_valid(sc_valid), .wr_ready(sc_ready),
        .wr_score(score), .wr_v_vec(sc_v_vec), .wr_last(sc_last),
        .rd_valid(fb_valid), .rd_ready(fb_ready),
        .rd_score(fb_score), .rd_v_vec(fb_v_vec), .rd_last(fb_last)
    );

    softmax_accum u_accum (
        .clk(clk), .arst_n(arst_n),
        .fb_valid(fb_valid), .fb_ready(fb_ready),
        .fb_score(fb_score), .fb_v_vec(fb_v_vec), .fb_last(fb_last),
        .sum_valid(sum_valid), .sum_ready(sum_ready),
        .acc_vec(acc_vec), .weight_sum(weight_sum)
    );

    norm_divider u_div (
        .clk(clk), .arst_n(arst_n),
        .sum_valid(sum_valid), .sum_ready(sum_ready),
        .acc_vec(acc_vec), .weight_sum(weight_sum),
        .out_valid(out_valid), .out_ready(out_ready), .out_vec(out_vec)
    );

endmodule

// File: test/attn_pe_properties.sv
// Handshake assertions for the attention PE, bound to its top level
`timescale 1ns/1ns

module attn_pe_properties (
    input logic                                      clk,
    input logic                                      arst_n,
    input logic                                      in_valid,
    input logic                                      in_ready,
    input logic                                      sc_valid,
    input logic                                      out_valid,
    input logic                                      out_ready,
    input attn_pkg::elem_t [attn_pkg::embed_dim-1:0] out_vec
);

    // Reset leaves every stage empty
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && in_ready)
        else $error("Valid output or blocked input while in reset");

    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_vec))
        else $error("Output dropped or changed while stalled");

    // Accepted beat occupies the score register one cycle later
    in_load: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && in_ready |=> sc_valid)
        else $error("Accepted input did not reach the score register");

endmodule

bind attn_pe attn_pe_properties u_props (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
    .sc_valid(sc_valid), .out_valid(out_valid), .out_ready(out_ready), .out_vec(out_vec)
);

// File: test/attn_pe_checker.sv
// Output checker, compares each accepted output vector with the next expected one
`timescale 1ns/1ns

module attn_pe_checker (
    input logic                                      clk,
    input logic                                      arst_n,
    input logic                                      out_valid,
    input logic                                      out_ready,
    input attn_pkg::elem_t [attn_pkg::embed_dim-1:0] out_vec
);
    import attn_pkg::*;

    typedef elem_t [embed_dim-1:0] vec_t;

    vec_t exp_q [$];       // Pushed by the testbench per finished sequence
    vec_t exp_vec;
    int   mismatches = 0;
    int   extra_outs = 0;
    int   out_count  = 0;

    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            out_count++;
            if (exp_q.size() == 0) begin
                extra_outs++;
                $display("Output at %0t arrived with no sequence outstanding", $time);
            end else begin
                exp_vec = exp_q.pop_front();
                if (out_vec !== exp_vec) begin
                    mismatches++;
                    $display("FAIL %0t out_vec got %h expected %h", $time, out_vec, exp_vec);
                end
            end
        end
    end

endmodule

// File: test/attn_pe_tb.sv
// Attention PE testbench, sends directed and random key/value sequences and checks results
`timescale 1ns/1ns

module attn_pe_tb;
    import attn_pkg::*;

    typedef elem_t [embed_dim-1:0] vec_t;

    localparam int wait_limit = 400;  // Cycles per wait

    logic clk       = 1'b0;
    logic out_ready = 1'b0;
    logic arst_n, in_valid, in_ready, in_last, out_valid;
    vec_t q_vec, k_vec, v_vec, out_vec;

    int   seq_score [$];  // Scores of the sequence being sent
    vec_t seq_v [$];
    int   sent_seqs = 0;
    int   timeouts  = 0;
    int   waited;

    always #50 clk = ~clk;

    always @(negedge clk) out_ready <= ($urandom % 4) != 0;  // Stall about one cycle in four

    attn_pe UUT (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
        .q_vec(q_vec), .k_vec(k_vec), .v_vec(v_vec), .in_last(in_last),
        .out_valid(out_valid), .out_ready(out_ready), .out_vec(out_vec)
    );

    attn_pe_checker u_checker (
        .clk(clk), .arst_n(arst_n), .out_valid(out_valid), .out_ready(out_ready),
        .out_vec(out_vec)
    );

    // Power-of-two softmax over the whole sequence
    function automatic vec_t attention_ref();
        longint m, w, d, q, wsum;
        longint acc [embed_dim];
        vec_t   res;
        m    = 0;
        wsum = 0;
        foreach (acc[i]) acc[i] = 0;
        foreach (seq_score[b]) begin
            d = seq_score[b] - m;
            w = longint'(1) << weight_frac;
            if (b > 0 && d > 0) begin
                wsum = wsum >>> d;  // Max rose, fade older totals
                foreach (acc[i]) acc[i] = acc[i] >>> d;
            end else if (b > 0) begin
                w = (-d > longint'(weight_frac)) ? longint'(0) : w >>> (-d);
            end
            if (b == 0 || d > 0) m = seq_score[b];
            wsum += w;
            foreach (acc[i]) acc[i] += w * elem_t'(seq_v[b][i]);
        end
        for (int i = 0; i < embed_dim; i++) begin
            q = acc[i] / wsum;
            res[i] = elem_t'((q > 127) ? longint'(127) : (q < -128) ? longint'(-128) : q);
        end
        return res;
    endfunction

    task automatic send_beat(input vec_t q, input vec_t k, input vec_t v, input logic last);
        int s;
        if (timeouts != 0) return;
        s = 0;
        for (int i = 0; i < embed_dim; i++) s += int'(elem_t'(q[i])) * int'(elem_t'(k[i]));
        @(negedge clk);
        in_valid = 1'b1;
        q_vec    = q;
        k_vec    = k;
        v_vec    = v;
        in_last  = last;
        waited   = 0;
        while (!in_ready && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            timeouts++;
            $display("Timeout at %0t, in_ready stayed low for %0d cycles", $time, wait_limit);
        end else begin
            seq_score.push_back(s);
            seq_v.push_back(v);
            if (last) begin
                u_checker.exp_q.push_back(attention_ref());
                sent_seqs++;
                seq_score.delete();
                seq_v.delete();
            end
        end
    endtask

    // Mode 0 random, 1 rising scores, 2 one dominant key, 3 extreme values
    task automatic send_sequence(input int n, input int mode);
        vec_t q, k, v;
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < embed_dim; i++) begin
                q[i] = (mode == 1) ? elem_t'(1) : (mode == 2) ? elem_t'(10) : elem_t'($urandom);
                k[i] = (mode == 1) ? elem_t'(3 * b) : elem_t'($urandom);
                if (mode == 2) k[i] = (b == 0) ? elem_t'(10) : elem_t'($urandom % 3);
                v[i] = elem_t'($urandom);
                if (mode == 3) v[i] = ($urandom % 2 != 0) ? elem_t'(127) : elem_t'(-128);
            end
            send_beat(q, k, v, b == n - 1);
        end
    endtask

    initial begin
        void'($urandom(32'hbf5e));
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_last  = 1'b0;
        q_vec    = '0;
        k_vec    = '0;
        v_vec    = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        send_sequence(1, 0);  // Single beat passes its value through
        send_sequence(4, 1);
        send_sequence(6, 2);
        send_sequence(5, 3);
        for (int n = 0; n < 40; n++) send_sequence(1 + $urandom % 8, $urandom % 4);
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;

        waited = 0;
        while (timeouts == 0 && u_checker.out_count < sent_seqs && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (timeouts == 0 && u_checker.out_count < sent_seqs) begin
            timeouts++;
            $display("Timeout at %0t, only %0d of %0d outputs arrived",
                     $time, u_checker.out_count, sent_seqs);
        end

        $display("Errors: %0d mismatches, %0d unexpected outputs, %0d timeouts",
                 u_checker.mismatches, u_checker.extra_outs, timeouts);
        if (u_checker.mismatches + u_checker.extra_outs + timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: attn_pe.f
hw/attn_pkg.sv
hw/score_unit.sv
hw/score_fifo.sv
hw/softmax_accum.sv
hw/norm_divider.sv
hw/attn_pe.sv
test/attn_pe_properties.sv
test/attn_pe_checker.sv
test/attn_pe_tb.sv

// File: Makefile
SRCS := $(shell cat attn_pe.f)

.PHONY: run clean

obj_dir/Vattn_pe_tb: attn_pe.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module attn_pe_tb \
		-f attn_pe.f -o Vattn_pe_tb

run: obj_dir/Vattn_pe_tb
	@out="$$(./obj_dir/Vattn_pe_tb)"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
